// File: sim.f
source/adder_cfg_pkg.sv
source/prefix_pkg.sv
source/pg_if.sv
source/carry_if.sv
source/pg_gen.sv
source/prefix_tree.sv
source/sum_stage.sv
source/ksa_adder_top.sv
tests/ksa_adder_tb.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

# build the testbench with assertions and timing enabled
verilator --binary --timing --assert \
    --top-module ksa_adder_tb \
    -f sim.f \
    -o ksa_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/ksa_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0

// File: tests/ksa_adder_tb.sv
`timescale 1ns/1ps

module ksa_adder_tb;

    localparam int WIDTH   = adder_cfg_pkg::DEFAULT_WIDTH;
    localparam int LPS     = adder_cfg_pkg::DEFAULT_LEVELS_PER_STAGE;
    localparam int LATENCY = adder_cfg_pkg::pipe_latency(WIDTH, LPS);
    localparam int DRAIN_TIMEOUT = LATENCY + 20;  // cycles
    localparam int SEED = 32'ha039;

    logic             clk = 1'b0;
    logic             rst;
    logic             in_valid;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic             cin;
    logic             out_valid;
    logic [WIDTH-1:0] sum;
    logic             cout;

    logic [WIDTH:0] exp_q[$];  // expected {cout, sum} per item
    int             age_q[$];  // cycles since the item was driven
    bit             tag_q[$];  // second item of a cin pair
    logic [WIDTH:0] prev_out;  // model value of the last result

    ksa_adder_top #(.WIDTH(WIDTH), .LEVELS_PER_STAGE(LPS)) DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .cin       (cin),
        .out_valid (out_valid),
        .sum       (sum),
        .cout      (cout)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [WIDTH-1:0] rand_word();
        return WIDTH'({$urandom(), $urandom()});
    endfunction

    task automatic check_outputs();
        logic [WIDTH:0] exp;
        bit             tag;
        if (rst) begin
            assert (out_valid == 1'b0) else stop_on_error("out_valid high during reset");
            assert (sum == '0)
                else stop_on_error($sformatf("mismatch sum expected %h got %h",
                                             {WIDTH{1'b0}}, sum));
            assert (cout == 1'b0)
                else stop_on_error($sformatf("mismatch cout expected %h got %h", 1'b0, cout));
        end else if (out_valid) begin
            assert (exp_q.size() > 0) else stop_on_error("out_valid high with no item queued");
            assert (age_q[0] == LATENCY)
                else stop_on_error($sformatf("result came %0d cycles after capture, not %0d",
                                             age_q[0], LATENCY));
            exp = exp_q.pop_front();
            tag = tag_q.pop_front();
            void'(age_q.pop_front());
            assert (sum == exp[WIDTH-1:0])
                else stop_on_error($sformatf("mismatch sum expected %h got %h",
                                             exp[WIDTH-1:0], sum));
            assert (cout == exp[WIDTH])
                else stop_on_error($sformatf("mismatch cout expected %h got %h",
                                             exp[WIDTH], cout));
            if (tag) begin  // cin set on the second of the pair
                assert ({cout, sum} == prev_out + (WIDTH+1)'(1))
                    else stop_on_error($sformatf("mismatch pair {cout,sum} expected %h got %h",
                                                 prev_out + (WIDTH+1)'(1), {cout, sum}));
            end
            prev_out = exp;
        end else begin
            assert (exp_q.size() == 0 || age_q[0] < LATENCY)
                else stop_on_error("queued result did not arrive on time");
        end
    endtask

    // one clock: age the queue, check what the edge produced, then drive the next inputs
    task automatic drive(input logic rst_v, input logic v, input logic [WIDTH-1:0] av,
                         input logic [WIDTH-1:0] bv, input logic cv, input bit tag);
        @(posedge clk);
        #1;
        foreach (age_q[i]) age_q[i]++;
        check_outputs();
        rst      = rst_v;
        in_valid = v;
        a        = av;
        b        = bv;
        cin      = cv;
        if (rst_v) begin  // anything in flight is flushed
            exp_q.delete();
            age_q.delete();
            tag_q.delete();
        end else if (v) begin
            exp_q.push_back((WIDTH+1)'(av) + (WIDTH+1)'(bv) + (WIDTH+1)'(cv));
            age_q.push_back(0);
            tag_q.push_back(tag);
        end
    endtask

    task automatic apply_reset(input int cycles);
        repeat (cycles) drive(1'b1, 1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    initial begin
        logic [WIDTH-1:0] x;
        logic [WIDTH-1:0] y;
        logic [WIDTH-1:0] ones;
        logic [WIDTH-1:0] alt;
        int               waited;
        void'($urandom(SEED));
        ones     = '1;
        alt      = {(WIDTH/2){2'b01}};
        rst      = 1'b1;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        cin      = 1'b0;
        prev_out = '0;
        apply_reset(3);  // rst is already high on the first edge

        // back to back random items
        repeat (2000) drive(1'b0, 1'b1, rand_word(), rand_word(), 1'($urandom_range(0, 1)), 1'b0);

        // long carry chains
        drive(1'b0, 1'b1, ones, '0, 1'b1, 1'b0);
        drive(1'b0, 1'b1, ones, ones, 1'b0, 1'b0);
        drive(1'b0, 1'b1, ones, ones, 1'b1, 1'b0);
        drive(1'b0, 1'b1, alt, ~alt, 1'b1, 1'b0);
        drive(1'b0, 1'b1, ~alt, alt, 1'b0, 1'b0);
        drive(1'b0, 1'b1, alt, alt, 1'b1, 1'b0);
        drive(1'b0, 1'b1, ~alt, ~alt, 1'b1, 1'b0);
        drive(1'b0, 1'b1, ones, WIDTH'(1), 1'b0, 1'b0);

        // random gaps
        repeat (1000) drive(1'b0, 1'($urandom_range(0, 1)), rand_word(), rand_word(),
                            1'($urandom_range(0, 1)), 1'b0);

        // reset with items in flight, then idle with nothing expected
        repeat (LATENCY - 1) drive(1'b0, 1'b1, rand_word(), rand_word(), 1'b1, 1'b0);
        apply_reset(4);
        repeat (12) drive(1'b0, 1'b0, rand_word(), rand_word(), 1'b0, 1'b0);
        repeat (50) drive(1'b0, 1'b1, rand_word(), rand_word(), 1'($urandom_range(0, 1)), 1'b0);

        // cin isolation pairs
        repeat (200) begin
            x = rand_word();
            y = rand_word();
            drive(1'b0, 1'b1, x, y, 1'b0, 1'b0);
            drive(1'b0, 1'b1, x, y, 1'b1, 1'b1);
        end

        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            drive(1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
            waited++;
        end
        if (exp_q.size() != 0) begin
            stop_on_error("timeout while draining the result queue");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    // bound on the whole run
    initial begin
        #200000;
        stop_on_error("watchdog expired before the test finished");
    end

endmodule

// File: source/ksa_adder_top.sv
`timescale 1ns/1ps

module ksa_adder_top #(
    parameter int WIDTH            = adder_cfg_pkg::DEFAULT_WIDTH,
    parameter int LEVELS_PER_STAGE = adder_cfg_pkg::DEFAULT_LEVELS_PER_STAGE
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic             out_valid,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    localparam int LATENCY = adder_cfg_pkg::pipe_latency(WIDTH, LEVELS_PER_STAGE);
    localparam int CNT_W   = $clog2(LATENCY + 1);

    pg_if    #(.WIDTH(WIDTH)) pg_bus ();
    carry_if #(.WIDTH(WIDTH)) carry_bus ();

    pg_gen #(.WIDTH(WIDTH)) u_pg_gen (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .cin      (cin),
        .pg       (pg_bus.src)
    );

    prefix_tree #(
        .WIDTH            (WIDTH),
        .LEVELS_PER_STAGE (LEVELS_PER_STAGE)
    ) u_prefix_tree (
        .clk   (clk),
        .rst   (rst),
        .pg    (pg_bus.dst),
        .carry (carry_bus.src)
    );

    sum_stage #(.WIDTH(WIDTH)) u_sum_stage (
        .clk       (clk),
        .rst       (rst),
        .carry     (carry_bus.dst),
        .out_valid (out_valid),
        .sum       (sum),
        .cout      (cout)
    );

    logic [CNT_W-1:0] settle_cnt;  // cycles since reset release, saturates

    always_ff @(posedge clk) begin
        if (rst) begin
            settle_cnt <= '0;
        end else if (settle_cnt != CNT_W'(LATENCY)) begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    // once the pipe is flushed every strobe comes out LATENCY cycles later
    latency_a: assert property (@(posedge clk) disable iff (rst)
        (settle_cnt == CNT_W'(LATENCY)) |-> (out_valid == $past(in_valid, LATENCY)));

endmodule

// File: source/sum_stage.sv
`timescale 1ns/1ps

module sum_stage #(
    parameter int WIDTH = adder_cfg_pkg::DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             rst,
    carry_if.dst             carry,
    output logic             out_valid,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    logic [WIDTH-1:0] sum_d;

    // half-sum xor carry into each bit
    assign sum_d = carry.p ^ carry.carry;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            sum       <= '0;
            cout      <= 1'b0;
        end else begin
            out_valid <= carry.valid;
            sum       <= sum_d;
            cout      <= carry.cout;
        end
    end

    out_valid_known_a: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(out_valid));

endmodule

// File: source/prefix_tree.sv
`timescale 1ns/1ps

module prefix_tree #(
    parameter int WIDTH            = adder_cfg_pkg::DEFAULT_WIDTH,
    parameter int LEVELS_PER_STAGE = adder_cfg_pkg::DEFAULT_LEVELS_PER_STAGE
) (
    input  logic clk,
    input  logic rst,
    pg_if.dst    pg,
    carry_if.src carry
);

    localparam int LEVELS = adder_cfg_pkg::tree_levels(WIDTH);
    localparam int REGS   = (LEVELS - 1) / LEVELS_PER_STAGE;  // register banks in the tree
    localparam int LAST   = LEVELS - 1;

    // node 0 is the carry-in, node i+1 is operand bit i
    prefix_pkg::pg_pair_t [WIDTH:0] base;

    always_comb begin
        base[0] = '{p: 1'b0, g: pg.cin};
        for (int i = 0; i < WIDTH; i++) begin
            base[i+1] = '{p: pg.p[i], g: pg.g[i]};
        end
    end

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_lvl
        localparam int DIST = 1 << lvl;

        prefix_pkg::pg_pair_t [WIDTH:0] d;    // level input
        prefix_pkg::pg_pair_t [WIDTH:0] nxt;  // after combine
        prefix_pkg::pg_pair_t [WIDTH:0] q;    // level output
        logic [WIDTH-1:0] p_in;
        logic [WIDTH-1:0] p_q;
        logic             v_in;
        logic             v_q;

        if (lvl == 0) begin : g_first
            assign d    = base;
            assign p_in = pg.p;
            assign v_in = pg.valid;
        end else begin : g_next
            assign d    = g_lvl[lvl-1].q;
            assign p_in = g_lvl[lvl-1].p_q;
            assign v_in = g_lvl[lvl-1].v_q;
        end

        // each node looks DIST positions down
        for (genvar j = 0; j <= WIDTH; j++) begin : g_pos
            if (j >= DIST) begin : g_op
                assign nxt[j] = prefix_pkg::combine(d[j], d[j-DIST]);
            end else begin : g_thru
                assign nxt[j] = prefix_pkg::pass(d[j]);
            end
        end

        // bank after every LEVELS_PER_STAGE levels, the last level stays open
        if ((lvl + 1) % LEVELS_PER_STAGE == 0 && lvl + 1 < LEVELS) begin : g_reg
            always_ff @(posedge clk) begin
                q   <= nxt;
                p_q <= p_in;
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    v_q <= 1'b0;
                end else begin
                    v_q <= v_in;
                end
            end
        end else begin : g_comb
            assign q   = nxt;
            assign p_q = p_in;
            assign v_q = v_in;
        end
    end

    // group generate of node i is the carry into bit i
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            carry.carry[i] = g_lvl[LAST].q[i].g;
        end
    end

    assign carry.cout  = g_lvl[LAST].q[WIDTH].g;  // spans every bit and cin
    assign carry.p     = g_lvl[LAST].p_q;
    assign carry.valid = g_lvl[LAST].v_q;

    initial begin
        levels_per_stage_a: assert (LEVELS_PER_STAGE >= 1 && LEVELS_PER_STAGE <= LEVELS)
            else $error("prefix_tree: LEVELS_PER_STAGE %0d outside 1..%0d",
                        LEVELS_PER_STAGE, LEVELS);
    end

    if (REGS > 0) begin : g_chk
        // a strobe leaving the tree must have entered REGS cycles before
        valid_delay_a: assert property (@(posedge clk) disable iff (rst)
            carry.valid |-> $past(pg.valid, REGS));
    end

endmodule

// File: source/pg_gen.sv
`timescale 1ns/1ps

module pg_gen #(
    parameter int WIDTH = adder_cfg_pkg::DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    pg_if.src                pg
);

    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] b_q;
    logic             cin_q;
    logic             valid_q;
    prefix_pkg::pg_pair_t [WIDTH-1:0] bit_pg;  // one pair per operand bit

    always_ff @(posedge clk) begin
        a_q   <= a;
        b_q   <= b;
        cin_q <= cin;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            bit_pg[i].p = a_q[i] ^ b_q[i];
            bit_pg[i].g = a_q[i] & b_q[i];
            pg.p[i]     = bit_pg[i].p;
            pg.g[i]     = bit_pg[i].g;
        end
    end

    assign pg.cin   = cin_q;
    assign pg.valid = valid_q;

    // nothing leaves the input register while reset is held
    reset_clears_valid_a: assert property (@(posedge clk) rst |=> !pg.valid);

endmodule

// File: source/carry_if.sv
`timescale 1ns/1ps

// tree results handed to the sum stage
interface carry_if #(
    parameter int WIDTH = adder_cfg_pkg::DEFAULT_WIDTH
);
    logic [WIDTH-1:0] p;      // bitwise propagate, delayed with the tree
    logic [WIDTH-1:0] carry;  // carry into each bit, bit 0 is cin
    logic             cout;
    logic             valid;

    modport src (
        output p,
        output carry,
        output cout,
        output valid
    );

    modport dst (
        input p,
        input carry,
        input cout,
        input valid
    );
endinterface

// File: source/pg_if.sv
`timescale 1ns/1ps

// bitwise p/g from the input register into the prefix tree
interface pg_if #(
    parameter int WIDTH = adder_cfg_pkg::DEFAULT_WIDTH
);
    logic [WIDTH-1:0] p;  // a ^ b
    logic [WIDTH-1:0] g;  // a & b
    logic             cin;
    logic             valid;

    modport src (
        output p,
        output g,
        output cin,
        output valid
    );

    modport dst (
        input p,
        input g,
        input cin,
        input valid
    );
endinterface

// File: source/prefix_pkg.sv
package prefix_pkg;

    // group propagate and group generate of one prefix node
    typedef struct packed {
        logic p;
        logic g;
    } pg_pair_t;

    // hi covers the upper bits, lo the bits right below it
    function automatic pg_pair_t combine(input pg_pair_t hi, input pg_pair_t lo);
        pg_pair_t res;
        res.g = hi.g | (hi.p & lo.g);
        res.p = hi.p & lo.p;
        return res;
    endfunction

    // no partner at this distance, node passes through
    function automatic pg_pair_t pass(input pg_pair_t node);
        pg_pair_t res;
        res = node;
        return res;
    endfunction

endpackage

// File: source/adder_cfg_pkg.sv
package adder_cfg_pkg;

    localparam int DEFAULT_WIDTH = 64;
    localparam int DEFAULT_LEVELS_PER_STAGE = 3;

    // prefix levels needed to span width bits plus the carry-in slot
    function automatic int tree_levels(input int width);
        int n;
        n = 0;
        while ((1 << n) < width + 1) begin
            n++;
        end
        return n;
    endfunction

    // input reg, one reg per full group of tree levels, output reg
    function automatic int pipe_latency(input int width, input int levels_per_stage);
        return 2 + (tree_levels(width) - 1) / levels_per_stage;
    endfunction

endpackage
